// ==== Makefile ====
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
		--top-module tb_ooo_core -f compile.f
	out="$$(./obj_dir/Vtb_ooo_core)"; echo "$$out"; echo "$$out" | grep -q "Regression passed"

clean:
	rm -rf obj_dir

// ==== alu_unit.sv ====
// integer ALU, result and tag registered onto the common data bus
`timescale 1ns/1ps

module alu_unit
  import ooo_pkg::*;
(
  input  logic                clk_in,
  input  logic                rst_n,
  input  logic                rdy,
  input  logic                exec_valid,
  input  alu_op_e             exec_op,
  input  logic [ROB_ID_W-1:0] exec_tag,
  input  logic [XLEN-1:0]     exec_a,
  input  logic [XLEN-1:0]     exec_b,
  output cdb_t                cdb
);

  logic [4:0]          shamt;
  logic [XLEN-1:0]     result;
  logic                bus_valid;
  logic [ROB_ID_W-1:0] bus_tag;
  logic [XLEN-1:0]     bus_value;

  assign shamt = exec_b[4:0];

  always_comb begin
    case (exec_op)
      ADD:     result = exec_a + exec_b;
      SUB:     result = exec_a - exec_b;
      AND:     result = exec_a & exec_b;
      OR:      result = exec_a | exec_b;
      XOR:     result = exec_a ^ exec_b;
      SLL:     result = exec_a << shamt;
      SRL:     result = exec_a >> shamt;
      SRA:     result = $signed(exec_a) >>> shamt;
      SLT:     result = {{(XLEN-1){1'b0}}, $signed(exec_a) < $signed(exec_b)};
      SLTU:    result = {{(XLEN-1){1'b0}}, exec_a < exec_b};
      default: result = '0;
    endcase
  end

  always_ff @(posedge clk_in or negedge rst_n) begin
    if (!rst_n) begin
      bus_valid <= 1'b0;
    end else if (rdy) begin
      bus_valid <= exec_valid;
    end
  end

  always_ff @(posedge clk_in) begin
    if (rdy && exec_valid) begin
      bus_tag   <= exec_tag;
      bus_value <= result;
    end
  end

  assign cdb = '{valid: bus_valid, rob_id: bus_tag, value: bus_value};

endmodule

// ==== compile.f ====
ooo_pkg.sv
register_file.sv
reorder_buffer.sv
reservation_station.sv
alu_unit.sv
dispatch_unit.sv
ooo_core.sv
ooo_checker.sv
tb_ooo_core.sv

// ==== dispatch_unit.sv ====
// dispatch, accepts an issue request and resolves its operands
// allocates the ROB slot and writes the RS entry on the same edge
`timescale 1ns/1ps

module dispatch_unit
  import ooo_pkg::*;
(
  input  logic                  issue_valid,
  input  issue_req_t            issue_req,
  output logic                  issue_ready,
  input  logic                  rdy,
  input  operand_t              rf_op1,
  input  operand_t              rf_op2,
  input  logic                  rob_look1_ready,
  input  logic [XLEN-1:0]       rob_look1_value,
  input  logic                  rob_look2_ready,
  input  logic [XLEN-1:0]       rob_look2_value,
  input  cdb_t                  cdb,
  input  logic [ROB_ID_W-1:0]   rob_tail_tag,
  input  logic                  rob_full,
  input  logic                  rs_full,
  output logic                  alloc_valid,
  output logic [REG_ADDR_W-1:0] alloc_rd,
  output logic                  rs_entry_valid,
  output rs_entry_t             rs_entry
);

  // busy operand: done in the ROB, or arriving on the CDB this cycle
  function automatic operand_t resolve(operand_t rf_op, logic rob_ready,
                                       logic [XLEN-1:0] rob_value, cdb_t bus);
    operand_t res;
    res = rf_op;
    if (rf_op.busy && rob_ready) begin
      res.busy  = 1'b0;
      res.value = rob_value;
    end else if (rf_op.busy && bus.valid && bus.rob_id == rf_op.tag) begin
      res.busy  = 1'b0;
      res.value = bus.value;
    end
    return res;
  endfunction

  logic accept;

  assign issue_ready = rdy && !rob_full && !rs_full;
  assign accept      = issue_valid && issue_ready;

  assign alloc_valid    = accept;
  assign alloc_rd       = issue_req.rd;
  assign rs_entry_valid = accept;

  assign rs_entry.op     = issue_req.op;
  assign rs_entry.rob_id = rob_tail_tag;
  assign rs_entry.src1   = resolve(rf_op1, rob_look1_ready, rob_look1_value, cdb);
  assign rs_entry.src2   = issue_req.use_imm ?
                           '{busy: 1'b0, tag: '0, value: issue_req.imm} :
                           resolve(rf_op2, rob_look2_ready, rob_look2_value, cdb);

endmodule

// ==== ooo_checker.sv ====
// commit checker for the out-of-order core
// compares each retired result with the expected results in issue order
`timescale 1ns/1ps

module ooo_checker
  import ooo_pkg::*;
(
  input  logic                  clk_in,
  input  logic                  rst_n,
  input  logic                  rdy,
  input  logic                  issue_valid,
  input  logic                  issue_ready,
  input  logic [REG_ADDR_W-1:0] exp_rd,
  input  logic [XLEN-1:0]       exp_value,
  input  logic                  commit_valid,
  input  logic [REG_ADDR_W-1:0] commit_rd,
  input  logic [XLEN-1:0]       commit_value,
  output int                    pending,
  output int                    checked_count,
  output int                    error_count
);

  // expected rd in the upper bits, value below
  logic [REG_ADDR_W+XLEN-1:0] exp_q [$];

  // mid-cycle sample of what the next rising edge retires and accepts
  always @(negedge clk_in or negedge rst_n) begin
    logic [REG_ADDR_W+XLEN-1:0] head;
    int errs;
    int seen;
    if (!rst_n) begin
      exp_q.delete();
      pending       <= 0;
      checked_count <= 0;
      error_count   <= 0;
    end else begin
      errs = 0;
      seen = 0;
      if (commit_valid && !rdy) begin
        $display("commit at time %0t while rdy was low", $time);
        errs++;
      end
      if (commit_valid && exp_q.size() == 0) begin
        $display("commit to x%0d at time %0t with no instruction outstanding", commit_rd, $time);
        errs++;
      end else if (commit_valid) begin
        head = exp_q.pop_front();
        seen = 1;
        if (commit_rd !== head[XLEN +: REG_ADDR_W]) begin
          $display("Fail time=%0t signal=commit_rd expected=%0d actual=%0d",
                   $time, head[XLEN +: REG_ADDR_W], commit_rd);
          errs++;
        end
        if (commit_value !== head[XLEN-1:0]) begin
          $display("Fail time=%0t signal=commit_value expected=%h actual=%h",
                   $time, head[XLEN-1:0], commit_value);
          errs++;
        end
      end
      // pushed after the pop since a result never retires on its own issue edge
      if (issue_valid && issue_ready && rdy) begin
        exp_q.push_back({exp_rd, exp_value});
      end
      pending       <= exp_q.size();
      checked_count <= checked_count + seen;
      error_count   <= error_count + errs;
    end
  end

endmodule

// ==== ooo_core.sv ====
// out-of-order core top, dispatch, RS, ALU and ROB around the register file
`timescale 1ns/1ps

module ooo_core
  import ooo_pkg::*;
(
  input  logic                  clk_in,
  input  logic                  rst_n,
  input  logic                  rdy,
  input  logic                  issue_valid,
  input  issue_req_t            issue_req,
  output logic                  issue_ready,
  output logic                  commit_valid,
  output logic [REG_ADDR_W-1:0] commit_rd,
  output logic [XLEN-1:0]       commit_value
);

  operand_t              rf_op1;
  operand_t              rf_op2;
  logic                  look1_ready;
  logic [XLEN-1:0]       look1_value;
  logic                  look2_ready;
  logic [XLEN-1:0]       look2_value;
  logic                  alloc_valid;
  logic [REG_ADDR_W-1:0] alloc_rd;
  logic [ROB_ID_W-1:0]   rob_tail;
  logic                  rob_full;
  logic                  rs_full;
  logic                  rs_entry_valid;
  rs_entry_t             rs_entry;
  logic                  exec_valid;
  alu_op_e               exec_op;
  logic [ROB_ID_W-1:0]   exec_tag;
  logic [XLEN-1:0]       exec_a;
  logic [XLEN-1:0]       exec_b;
  cdb_t                  cdb;
  logic [ROB_ID_W-1:0]   commit_tag;

  dispatch_unit dispatch_i (
    .issue_valid(issue_valid), .issue_req(issue_req), .issue_ready(issue_ready), .rdy(rdy),
    .rf_op1(rf_op1), .rf_op2(rf_op2),
    .rob_look1_ready(look1_ready), .rob_look1_value(look1_value),
    .rob_look2_ready(look2_ready), .rob_look2_value(look2_value),
    .cdb(cdb), .rob_tail_tag(rob_tail), .rob_full(rob_full), .rs_full(rs_full),
    .alloc_valid(alloc_valid), .alloc_rd(alloc_rd),
    .rs_entry_valid(rs_entry_valid), .rs_entry(rs_entry)
  );

  // the ROB lookups use the rename tags straight from the register file
  register_file register_file_i (
    .clk_in(clk_in), .rst_n(rst_n), .rdy(rdy),
    .rs1(issue_req.rs1), .rs2(issue_req.rs2), .op1(rf_op1), .op2(rf_op2),
    .alloc_valid(alloc_valid), .alloc_rd(alloc_rd), .alloc_tag(rob_tail),
    .commit_valid(commit_valid), .commit_rd(commit_rd),
    .commit_tag(commit_tag), .commit_value(commit_value)
  );

  reorder_buffer reorder_buffer_i (
    .clk_in(clk_in), .rst_n(rst_n), .rdy(rdy),
    .alloc_valid(alloc_valid), .alloc_rd(alloc_rd), .tail_tag(rob_tail), .full(rob_full),
    .look1_tag(rf_op1.tag), .look2_tag(rf_op2.tag),
    .look1_ready(look1_ready), .look1_value(look1_value),
    .look2_ready(look2_ready), .look2_value(look2_value),
    .cdb(cdb), .commit_valid(commit_valid), .commit_rd(commit_rd),
    .commit_tag(commit_tag), .commit_value(commit_value)
  );

  reservation_station reservation_station_i (
    .clk_in(clk_in), .rst_n(rst_n), .rdy(rdy),
    .entry_valid(rs_entry_valid), .entry(rs_entry), .full(rs_full), .cdb(cdb),
    .exec_valid(exec_valid), .exec_op(exec_op), .exec_tag(exec_tag),
    .exec_a(exec_a), .exec_b(exec_b)
  );

  alu_unit alu_unit_i (
    .clk_in(clk_in), .rst_n(rst_n), .rdy(rdy),
    .exec_valid(exec_valid), .exec_op(exec_op), .exec_tag(exec_tag),
    .exec_a(exec_a), .exec_b(exec_b), .cdb(cdb)
  );

endmodule

// ==== ooo_pkg.sv ====
// shared sizes, opcodes and bus structs for the out-of-order integer core
// one ALU, one reservation station and a reorder buffer around a register file
package ooo_pkg;

  // datapath and register file
  localparam int XLEN       = 32;
  localparam int REG_ADDR_W = 5;
  localparam int NUM_REGS   = 1 << REG_ADDR_W;

  // reorder buffer, tag is the slot index
  localparam int ROB_DEPTH = 8;
  localparam int ROB_ID_W  = 3;

  // reservation station
  localparam int RS_DEPTH = 4;
  localparam int RS_IDX_W = 2;

  typedef enum logic [3:0] {
    ADD  = 4'd0,
    SUB  = 4'd1,
    AND  = 4'd2,
    OR   = 4'd3,
    XOR  = 4'd4,
    SLL  = 4'd5,
    SRL  = 4'd6,
    SRA  = 4'd7,
    SLT  = 4'd8,
    SLTU = 4'd9
  } alu_op_e;

  // decoded instruction on the issue port
  typedef struct packed {
    alu_op_e               op;
    logic [REG_ADDR_W-1:0] rd;
    logic [REG_ADDR_W-1:0] rs1;
    logic [REG_ADDR_W-1:0] rs2;
    logic [XLEN-1:0]       imm;
    logic                  use_imm;
  } issue_req_t;

  // source operand, either a value or the tag of its producer
  typedef struct packed {
    logic                busy;
    logic [ROB_ID_W-1:0] tag;
    logic [XLEN-1:0]     value;
  } operand_t;

  typedef struct packed {
    logic                valid;
    logic [ROB_ID_W-1:0] rob_id;
    logic [XLEN-1:0]     value;
  } cdb_t;

  typedef struct packed {
    alu_op_e             op;
    logic [ROB_ID_W-1:0] rob_id;
    operand_t            src1;
    operand_t            src2;
  } rs_entry_t;

endpackage

// ==== register_file.sv ====
// architectural register file with a rename tag per register
// two operand reads for dispatch, allocation marks busy, commit writes back
`timescale 1ns/1ps

module register_file
  import ooo_pkg::*;
(
  input  logic                  clk_in,
  input  logic                  rst_n,
  input  logic                  rdy,
  input  logic [REG_ADDR_W-1:0] rs1,
  input  logic [REG_ADDR_W-1:0] rs2,
  output operand_t              op1,
  output operand_t              op2,
  input  logic                  alloc_valid,
  input  logic [REG_ADDR_W-1:0] alloc_rd,
  input  logic [ROB_ID_W-1:0]   alloc_tag,
  input  logic                  commit_valid,
  input  logic [REG_ADDR_W-1:0] commit_rd,
  input  logic [ROB_ID_W-1:0]   commit_tag,
  input  logic [XLEN-1:0]       commit_value
);

  logic [XLEN-1:0]     regs [NUM_REGS];
  logic [ROB_ID_W-1:0] tags [NUM_REGS];
  logic [NUM_REGS-1:0] busy;

  // x0 is never written, so its reset value keeps it at zero
  assign op1 = '{busy: busy[rs1], tag: tags[rs1], value: regs[rs1]};
  assign op2 = '{busy: busy[rs2], tag: tags[rs2], value: regs[rs2]};

  always_ff @(posedge clk_in or negedge rst_n) begin
    if (!rst_n) begin
      busy <= '0;
      for (int i = 0; i < NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (rdy) begin
      if (commit_valid && commit_rd != '0) begin
        regs[commit_rd] <= commit_value;
        // a newer producer keeps the register renamed
        if (tags[commit_rd] == commit_tag) begin
          busy[commit_rd] <= 1'b0;
        end
      end
      // same-cycle allocation overrides the commit clear
      if (alloc_valid && alloc_rd != '0) begin
        busy[alloc_rd] <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk_in) begin
    if (rdy && alloc_valid && alloc_rd != '0) begin
      tags[alloc_rd] <= alloc_tag;
    end
  end

  x0_never_busy: assert property (@(posedge clk_in) disable iff (!rst_n) !busy[0])
    else $error("x0 marked busy");

endmodule

// ==== reorder_buffer.sv ====
// reorder buffer, holds in-flight results by tag and retires them in issue order
// also answers the operand lookups made at dispatch
`timescale 1ns/1ps

module reorder_buffer
  import ooo_pkg::*;
(
  input  logic                  clk_in,
  input  logic                  rst_n,
  input  logic                  rdy,
  input  logic                  alloc_valid,
  input  logic [REG_ADDR_W-1:0] alloc_rd,
  output logic [ROB_ID_W-1:0]   tail_tag,
  output logic                  full,
  input  logic [ROB_ID_W-1:0]   look1_tag,
  input  logic [ROB_ID_W-1:0]   look2_tag,
  output logic                  look1_ready,
  output logic [XLEN-1:0]       look1_value,
  output logic                  look2_ready,
  output logic [XLEN-1:0]       look2_value,
  input  cdb_t                  cdb,
  output logic                  commit_valid,
  output logic [REG_ADDR_W-1:0] commit_rd,
  output logic [ROB_ID_W-1:0]   commit_tag,
  output logic [XLEN-1:0]       commit_value
);

  logic [ROB_ID_W-1:0]   head;
  logic [ROB_ID_W-1:0]   tail;
  logic [ROB_ID_W:0]     count;
  logic [ROB_ID_W:0]     count_next;
  logic [ROB_DEPTH-1:0]  done;
  logic [REG_ADDR_W-1:0] dest [ROB_DEPTH];
  logic [XLEN-1:0]       result [ROB_DEPTH];
  logic [ROB_ID_W-1:0]   cdb_off;

  assign tail_tag = tail;

  assign look1_ready = done[look1_tag];
  assign look1_value = result[look1_tag];
  assign look2_ready = done[look2_tag];
  assign look2_value = result[look2_tag];

  // head retires once its result has landed
  assign commit_valid = rdy && (count != '0) && done[head];
  assign commit_rd    = dest[head];
  assign commit_tag   = head;
  assign commit_value = result[head];

  always_comb begin
    count_next = count;
    if (alloc_valid) begin
      count_next = count_next + 1'b1;
    end
    if (commit_valid) begin
      count_next = count_next - 1'b1;
    end
  end

  // full comes up through reset so nothing issues before the first clock
  always_ff @(posedge clk_in or negedge rst_n) begin
    if (!rst_n) begin
      head  <= '0;
      tail  <= '0;
      count <= '0;
      done  <= '0;
      full  <= 1'b1;
    end else if (rdy) begin
      count <= count_next;
      full  <= (count_next == (ROB_ID_W+1)'(ROB_DEPTH));
      if (commit_valid) begin
        head <= head + 1'b1;
      end
      if (cdb.valid) begin
        done[cdb.rob_id] <= 1'b1;
      end
      if (alloc_valid) begin
        done[tail] <= 1'b0;
        tail       <= tail + 1'b1;
      end
    end
  end

  always_ff @(posedge clk_in) begin
    if (rdy && alloc_valid) begin
      dest[tail] <= alloc_rd;
    end
    if (rdy && cdb.valid) begin
      result[cdb.rob_id] <= cdb.value;
    end
  end

  assign cdb_off = cdb.rob_id - head;

  no_alloc_when_full: assert property (@(posedge clk_in) disable iff (!rst_n)
    alloc_valid |-> !full) else $error("ROB allocation while full");

  cdb_hits_live_entry: assert property (@(posedge clk_in) disable iff (!rst_n)
    (rdy && cdb.valid) |-> ({1'b0, cdb_off} < count)) else $error("CDB tag not in flight");

endmodule

// ==== reservation_station.sv ====
// reservation station for the ALU, wakes operands from the CDB
// and sends the oldest entry with both operands ready
`timescale 1ns/1ps

module reservation_station
  import ooo_pkg::*;
(
  input  logic                clk_in,
  input  logic                rst_n,
  input  logic                rdy,
  input  logic                entry_valid,
  input  rs_entry_t           entry,
  output logic                full,
  input  cdb_t                cdb,
  output logic                exec_valid,
  output alu_op_e             exec_op,
  output logic [ROB_ID_W-1:0] exec_tag,
  output logic [XLEN-1:0]     exec_a,
  output logic [XLEN-1:0]     exec_b
);

  rs_entry_t           slots [RS_DEPTH];
  logic [RS_DEPTH-1:0] valid;
  logic [RS_DEPTH-1:0] ready;
  // older[j][i] set when slot j entered before slot i
  logic [RS_DEPTH-1:0] older [RS_DEPTH];
  logic                sel_valid;
  logic [RS_IDX_W-1:0] sel_idx;
  logic [RS_IDX_W-1:0] wr_idx;

  assign full = &valid;

  always_comb begin
    for (int i = 0; i < RS_DEPTH; i++) begin
      ready[i] = valid[i] && !slots[i].src1.busy && !slots[i].src2.busy;
    end
  end

  // pick the ready slot with no older ready slot
  always_comb begin
    logic blocked;
    sel_valid = 1'b0;
    sel_idx   = '0;
    for (int i = 0; i < RS_DEPTH; i++) begin
      blocked = 1'b0;
      for (int j = 0; j < RS_DEPTH; j++) begin
        if (j != i && ready[j] && older[j][i]) begin
          blocked = 1'b1;
        end
      end
      if (ready[i] && !blocked) begin
        sel_valid = 1'b1;
        sel_idx   = RS_IDX_W'(i);
      end
    end
  end

  // lowest free slot
  always_comb begin
    wr_idx = '0;
    for (int i = RS_DEPTH - 1; i >= 0; i--) begin
      if (!valid[i]) begin
        wr_idx = RS_IDX_W'(i);
      end
    end
  end

  always_ff @(posedge clk_in or negedge rst_n) begin
    if (!rst_n) begin
      valid      <= '0;
      exec_valid <= 1'b0;
    end else if (rdy) begin
      exec_valid <= sel_valid;
      if (sel_valid) begin
        valid[sel_idx] <= 1'b0;
      end
      if (entry_valid) begin
        valid[wr_idx] <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk_in) begin
    if (rdy) begin
      for (int i = 0; i < RS_DEPTH; i++) begin
        if (valid[i] && cdb.valid && slots[i].src1.busy && slots[i].src1.tag == cdb.rob_id) begin
          slots[i].src1 <= '{busy: 1'b0, tag: cdb.rob_id, value: cdb.value};
        end
        if (valid[i] && cdb.valid && slots[i].src2.busy && slots[i].src2.tag == cdb.rob_id) begin
          slots[i].src2 <= '{busy: 1'b0, tag: cdb.rob_id, value: cdb.value};
        end
      end
      if (entry_valid) begin
        slots[wr_idx] <= entry;
        for (int j = 0; j < RS_DEPTH; j++) begin
          older[j][wr_idx] <= (j != wr_idx);
          older[wr_idx][j] <= 1'b0;
        end
      end
      if (sel_valid) begin
        exec_op  <= slots[sel_idx].op;
        exec_tag <= slots[sel_idx].rob_id;
        exec_a   <= slots[sel_idx].src1.value;
        exec_b   <= slots[sel_idx].src2.value;
      end
    end
  end

  no_write_when_full: assert property (@(posedge clk_in) disable iff (!rst_n)
    entry_valid |-> !full) else $error("RS write while full");

endmodule

// ==== tb_ooo_core.sv ====
// testbench for the out-of-order core
// table of decoded instructions, sequential reference model and issue loop
`timescale 1ns/1ps

module tb_ooo_core
  import ooo_pkg::*;
;

  typedef struct packed {
    issue_req_t      req;
    logic [4:0]      rd;
    logic [XLEN-1:0] value;
  } step_t;

  logic                  clk_in;
  logic                  rst_n;
  logic                  rdy;
  logic                  issue_valid;
  issue_req_t            issue_req;
  logic                  issue_ready;
  logic                  commit_valid;
  logic [REG_ADDR_W-1:0] commit_rd;
  logic [XLEN-1:0]       commit_value;
  logic [REG_ADDR_W-1:0] exp_rd;
  logic [XLEN-1:0]       exp_value;
  int                    pending;
  int                    checked_count;
  int                    error_count;

  step_t       steps [$];
  logic [31:0] model_regs [32];
  logic [16:0] lfsr_state;
  bit          timed_out;
  bit          saw_backpressure;
  bit          burst_fail;
  int          test_base;

  ooo_core ooo_core_i (
    .clk_in(clk_in), .rst_n(rst_n), .rdy(rdy),
    .issue_valid(issue_valid), .issue_req(issue_req), .issue_ready(issue_ready),
    .commit_valid(commit_valid), .commit_rd(commit_rd), .commit_value(commit_value)
  );

  ooo_checker checker_i (
    .clk_in(clk_in), .rst_n(rst_n), .rdy(rdy),
    .issue_valid(issue_valid), .issue_ready(issue_ready),
    .exp_rd(exp_rd), .exp_value(exp_value),
    .commit_valid(commit_valid), .commit_rd(commit_rd), .commit_value(commit_value),
    .pending(pending), .checked_count(checked_count), .error_count(error_count)
  );

  always #50 clk_in = ~clk_in;

  // 17-bit Fibonacci LFSR with taps 17 and 14
  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = {lfsr_state[15:0], lfsr_state[16] ^ lfsr_state[13]};
      v = {v[30:0], lfsr_state[0]};
    end
    return v;
  endfunction

  // ISA meaning of each opcode
  function automatic logic [31:0] model_exec(alu_op_e op, logic [31:0] a, logic [31:0] b);
    logic [4:0] sh;
    sh = b[4:0];
    case (op)
      ADD:     return a + b;
      SUB:     return a + ~b + 32'd1;
      AND:     return a & b;
      OR:      return a | b;
      XOR:     return a ^ b;
      SLL:     return a << sh;
      SRL:     return a >> sh;
      SRA:     return (a >> sh) | (a[31] ? ~(32'hffff_ffff >> sh) : 32'h0);
      SLT:     return (a[31] != b[31]) ? {31'b0, a[31]} : {31'b0, a < b};
      SLTU:    return {31'b0, a < b};
      default: return 32'h0;
    endcase
  endfunction

  // builds one table row and runs it through the model in program order
  task automatic add_step(input alu_op_e op, input int rd, input int rs1, input int rs2,
                          input logic [31:0] imm, input bit use_imm);
    step_t       s;
    logic [31:0] b;
    s.req   = '{op: op, rd: 5'(rd), rs1: 5'(rs1), rs2: 5'(rs2), imm: imm, use_imm: use_imm};
    b       = use_imm ? imm : model_regs[rs2];
    s.rd    = 5'(rd);
    s.value = model_exec(op, model_regs[rs1], b);
    if (rd != 0) begin
      model_regs[rd] = s.value;
    end
    steps.push_back(s);
  endtask

  task automatic hold_rdy_low(input int cycles);
    issue_valid <= 1'b0;
    rdy         <= 1'b0;
    repeat (cycles) @(posedge clk_in);
    rdy <= 1'b1;
  endtask

  task automatic issue_step(input step_t s);
    int waited;
    bit accepted;
    issue_valid <= 1'b1;
    issue_req   <= s.req;
    exp_rd      <= s.rd;
    exp_value   <= s.value;
    waited   = 0;
    accepted = 0;
    while (!accepted && waited < 50) begin
      @(negedge clk_in);
      if (rdy && !issue_ready) begin
        saw_backpressure = 1;
      end
      accepted = issue_valid && issue_ready && rdy;
      @(posedge clk_in);
      waited++;
    end
    if (!accepted) begin
      $display("timeout: instruction for x%0d was never accepted", s.rd);
      timed_out = 1;
    end
  endtask

  task automatic run_table(input bit idle_gaps);
    step_t s;
    int    gap;
    while (steps.size() != 0 && !timed_out) begin
      s = steps.pop_front();
      if (idle_gaps) begin
        gap = take_bits(2);
        if (gap != 0) begin
          issue_valid <= 1'b0;
          repeat (gap) @(posedge clk_in);
        end
        if (take_bits(3) == 0) begin
          hold_rdy_low(2 + take_bits(2));
        end
      end
      issue_step(s);
    end
    steps.delete();
    issue_valid <= 1'b0;
  endtask

  // waits until every accepted instruction has retired
  task automatic finish_test(input string name);
    int waited;
    waited = 0;
    while (!timed_out && pending != 0 && waited < 200) begin
      @(posedge clk_in);
      waited++;
    end
    if (!timed_out && pending != 0) begin
      $display("timeout: %0d results of test %s never committed", pending, name);
      timed_out = 1;
    end
    $display("test %s finished with %0d errors", name, error_count - test_base);
    test_base = error_count;
  endtask

  initial begin
    alu_op_e op;
    clk_in      = 1'b0;
    rst_n       = 1'b0;
    rdy         = 1'b1;
    issue_valid = 1'b0;
    issue_req   = '0;
    exp_rd      = '0;
    exp_value   = '0;
    lfsr_state  = 17'd74625;
    timed_out   = 0;
    burst_fail  = 0;
    test_base   = 0;
    for (int i = 0; i < 32; i++) begin
      model_regs[i] = '0;
    end
    repeat (10) @(posedge clk_in);
    rst_n <= 1'b1;

    // x1 positive, x3 negative, so signed and unsigned compares differ
    add_step(ADD, 1, 0, 0, take_bits(32) & 32'h7fff_ffff, 1'b1);
    add_step(ADD, 2, 0, 0, take_bits(32), 1'b1);
    add_step(ADD, 3, 0, 0, take_bits(32) | 32'h8000_0000, 1'b1);
    for (int k = 0; k < 10; k++) begin
      op = alu_op_e'(k);
      add_step(op, 4 + k, (k >= 8) ? 1 : 3, (k >= 8) ? 3 : 2, 32'h0, 1'b0);
      add_step(op, 14 + k, 3, 0, take_bits(32), 1'b1);
    end
    run_table(1'b1);
    finish_test("opcodes");

    add_step(ADD, 5, 1, 2, 32'h0, 1'b0);
    add_step(SUB, 6, 5, 3, 32'h0, 1'b0);
    add_step(XOR, 5, 6, 5, 32'h0, 1'b0);
    add_step(SRA, 7, 5, 0, 32'd7, 1'b1);
    add_step(SLT, 7, 7, 6, 32'h0, 1'b0);
    add_step(OR, 8, 7, 5, 32'h0, 1'b0);
    add_step(SLL, 6, 8, 2, 32'h0, 1'b0);
    add_step(ADD, 8, 8, 8, 32'h0, 1'b0);
    run_table(1'b0);
    finish_test("raw_chain");

    add_step(ADD, 0, 1, 2, 32'h0, 1'b0);
    add_step(ADD, 9, 0, 0, 32'd5, 1'b1);
    add_step(XOR, 0, 9, 0, 32'hff, 1'b1);
    add_step(OR, 9, 0, 2, 32'h0, 1'b0);
    run_table(1'b1);
    finish_test("x0_writes");

    // each reads the previous result so the slow wakeup fills the RS
    for (int k = 0; k < 12; k++) begin
      add_step((k % 3 == 0) ? XOR : ADD, 10 + k, (k == 0) ? 2 : 9 + k, 0, take_bits(12), 1'b1);
    end
    saw_backpressure = 0;
    run_table(1'b0);
    if (!timed_out && !saw_backpressure) begin
      $display("issue_ready never dropped during the burst");
      burst_fail = 1;
    end
    finish_test("burst");

    for (int k = 0; k < 5; k++) begin
      add_step((k % 2 == 1) ? SUB : ADD, 24 + k, (k == 0) ? 1 : 23 + k, 2, 32'h0, 1'b0);
    end
    run_table(1'b0);
    hold_rdy_low(4 + take_bits(3));
    finish_test("rdy_stall");

    $display("commits checked %0d, errors %0d, timeouts %0d, burst failures %0d",
             checked_count, error_count, timed_out, burst_fail);
    if (error_count == 0 && !timed_out && !burst_fail) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule
